/* Makefile */
TOP := lsu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) +verilator+error+limit+100 | tee sim.log
	@if grep -q "ALL TESTS PASSED" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* bench/lsu_assertions.sv */
`timescale 1ns/1ps

module lsu_assertions (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            req_i,
  input  logic                            gnt_i,
  input  logic                            rvalid_i,
  input  logic                            we_i,
  input  logic [lsu_pkg::addr_width-1:0]  addr_i,
  input  logic [lsu_pkg::be_width-1:0]    be_i,
  input  logic [lsu_pkg::data_width-1:0]  wdata_i,
  input  logic                            resp_valid_i,
  input  logic                            ready_i
);

  logic outstanding;  // granted, rvalid not yet seen
  int   hold_fails   = 0;
  int   rvalid_fails = 0;
  int   resp_fails   = 0;
  int   fail_cnt;     // total of failed assertions

  assign fail_cnt = hold_fails + rvalid_fails + resp_fails;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding <= 1'b0;
    end else if (req_i && gnt_i) begin
      outstanding <= 1'b1;
    end else if (rvalid_i) begin
      outstanding <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // bus protocol
  ////////////////////////////////////////////////////////////
  // payload frozen while req waits for gnt
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i && !gnt_i |=> req_i && $stable(addr_i) && $stable(we_i) &&
                        $stable(be_i) && $stable(wdata_i))
    else begin
      hold_fails = hold_fails + 1;
      $error("bus request or payload changed before gnt");
    end

  rvalid_gnt_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> outstanding)
    else begin
      rvalid_fails = rvalid_fails + 1;
      $error("rvalid without an outstanding gnt");
    end

  // ready comes back only in the response cycle
  resp_ready_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ready_i) == resp_valid_i)
    else begin
      resp_fails = resp_fails + 1;
      $error("lsu_ready_o did not rise together with resp_valid_o");
    end

endmodule

/* bench/lsu_clk_gen.sv */
`timescale 1ns/1ps

module lsu_clk_gen (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #10 clk_o = ~clk_o;  // 20 ns period

endmodule

/* bench/lsu_patterns.txt */
// op size sign addr wdata expect err
// op 0 load 1 store, size 0 word 1 half 2 byte, err 0 none 1 first part 2 second part
1 0 0 00000010 deadbeef 00000000 0
0 0 0 00000010 00000000 deadbeef 0
0 2 1 00000010 00000000 ffffffef 0
0 1 0 00000012 00000000 0000dead 0
1 0 0 00000014 7f80ff01 00000000 0
0 2 1 00000015 00000000 ffffffff 0
0 2 0 00000016 00000000 00000080 0
0 2 1 00000017 00000000 0000007f 0
0 1 1 00000014 00000000 ffffff01 0
0 1 0 00000016 00000000 00007f80 0
0 1 1 00000015 00000000 ffff80ff 0
0 1 0 00000017 00000000 0000187f 0
0 0 0 00000013 00000000 80ff01de 0
1 0 0 00000021 11223344 00000000 0
0 0 0 00000020 00000000 22334420 0
0 0 0 00000024 00000000 27262511 0
1 2 0 0000002a 000000c5 00000000 0
1 1 0 0000002f 0000a55a 00000000 0
0 0 0 00000028 00000000 2bc52928 0
0 0 0 0000002c 00000000 5a2e2d2c 0
0 0 0 00000030 00000000 333231a5 0
0 0 0 00000040 00000000 43424140 1
0 0 0 00000045 00000000 48474645 2
0 2 0 00000053 00000000 00000053 0

/* bench/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

  localparam int max_pats = 64;
  localparam int pat_cols = 7;  // op size sign addr wdata expect err

  logic                            clk;
  logic                            rst_n       = 1'b0;
  logic                            ex_req      = 1'b0;
  logic                            ex_we       = 1'b0;
  logic [lsu_pkg::size_width-1:0]  ex_size     = lsu_pkg::size_word;
  logic                            ex_sign_ext = 1'b0;
  logic [lsu_pkg::addr_width-1:0]  ex_addr     = '0;
  logic [lsu_pkg::data_width-1:0]  ex_wdata    = '0;
  logic                            lsu_ready;
  logic                            resp_valid;
  logic [lsu_pkg::data_width-1:0]  resp_rdata;
  logic                            resp_err;
  logic                            data_req;
  logic                            data_gnt    = 1'b0;
  logic                            data_rvalid = 1'b0;
  logic                            data_we;
  logic [lsu_pkg::be_width-1:0]    data_be;
  logic [lsu_pkg::addr_width-1:0]  data_addr;
  logic [lsu_pkg::data_width-1:0]  data_wdata;
  logic [lsu_pkg::data_width-1:0]  data_rdata  = '0;
  logic                            data_err    = 1'b0;

  logic [31:0] pat_mem [0:max_pats*pat_cols-1];
  logic [7:0]  mem [0:255];   // byte memory, wraps at 256
  logic [31:0] txn_addr [$];  // granted addresses of current access
  int          n_pats;
  bit          pats_loaded = 1'b0;
  int          err_mode    = 0;  // 0 none, 1 first part, 2 second part
  int          gnt_cnt     = 0;
  int          rv_cnt      = 0;
  bit          pending     = 1'b0;
  logic [31:0] pend_addr;
  logic        pend_err;
  int          rdata_errs  = 0;
  int          flag_errs   = 0;
  int          bus_errs    = 0;
  int          other_errs  = 0;
  int          asrt_errs   = 0;

  lsu_clk_gen clk_gen_i (.clk_o(clk));

  lsu_top i_dut (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .ex_req_i      ( ex_req      ),
    .ex_we_i       ( ex_we       ),
    .ex_size_i     ( ex_size     ),
    .ex_sign_ext_i ( ex_sign_ext ),
    .ex_addr_i     ( ex_addr     ),
    .ex_wdata_i    ( ex_wdata    ),
    .lsu_ready_o   ( lsu_ready   ),
    .resp_valid_o  ( resp_valid  ),
    .resp_rdata_o  ( resp_rdata  ),
    .resp_err_o    ( resp_err    ),
    .data_req_o    ( data_req    ),
    .data_gnt_i    ( data_gnt    ),
    .data_rvalid_i ( data_rvalid ),
    .data_we_o     ( data_we     ),
    .data_be_o     ( data_be     ),
    .data_addr_o   ( data_addr   ),
    .data_wdata_o  ( data_wdata  ),
    .data_rdata_i  ( data_rdata  ),
    .data_err_i    ( data_err    )
  );

  bind lsu_bus_ctrl lsu_assertions bus_asrt_i (
    .clk_i        ( clk_i         ),
    .rst_n_i      ( rst_n_i       ),
    .req_i        ( data_req_o    ),
    .gnt_i        ( data_gnt_i    ),
    .rvalid_i     ( data_rvalid_i ),
    .we_i         ( data_we_o     ),
    .addr_i       ( data_addr_o   ),
    .be_i         ( data_be_o     ),
    .wdata_i      ( data_wdata_o  ),
    .resp_valid_i ( resp_valid_o  ),
    .ready_i      ( lsu_ready_o   )
  );

  ////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [7:0] a;
    a = {addr[7:2], 2'b00};
    return {mem[a + 8'd3], mem[a + 8'd2], mem[a + 8'd1], mem[a]};
  endfunction

  task automatic write_word(input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata);
    logic [7:0] a;
    a = {addr[7:2], 2'b00};
    for (int i = 0; i < 4; i++) begin
      if (be[i]) mem[a + i[7:0]] = wdata[8*i +: 8];  // enabled lanes only
    end
  endtask

  // gnt and rvalid each 0..3 cycles late
  always @(negedge clk) begin
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    data_err    = 1'b0;
    if (!rst_n) begin
      pending = 1'b0;
      gnt_cnt = 0;
    end else if (pending) begin
      if (rv_cnt == 0) begin
        data_rvalid = 1'b1;
        data_rdata  = read_word(pend_addr);
        data_err    = pend_err;
        pending     = 1'b0;
      end else begin
        rv_cnt = rv_cnt - 1;
      end
    end else if (data_req) begin
      if (gnt_cnt == 0) begin
        data_gnt  = 1'b1;
        pend_addr = data_addr;
        pend_err  = (err_mode == 1 && txn_addr.size() == 0) ||
                    (err_mode == 2 && txn_addr.size() == 1);
        txn_addr.push_back(data_addr);
        if (data_we) write_word(data_addr, data_be, data_wdata);
        pending = 1'b1;
        rv_cnt  = $urandom % 4;
        gnt_cnt = $urandom % 4;  // delay of the next grant
      end else begin
        gnt_cnt = gnt_cnt - 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_rdata(input int idx, input lsu_pkg::data_word_u got,
                             input lsu_pkg::data_word_u exp);
    if (got !== exp) begin
      rdata_errs++;
      $display("Mismatch resp_rdata_o: got %h expected %h (access %0d)", got, exp, idx);
    end
  endtask

  task automatic check_err(input int idx, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("Mismatch resp_err_o: got %h expected %h (access %0d)", got, exp, idx);
    end
  endtask

  task automatic check_addr(input int idx, input logic [lsu_pkg::addr_width-1:0] got,
                            input logic [lsu_pkg::addr_width-1:0] exp);
    if (got !== exp) begin
      bus_errs++;
      $display("Mismatch data_addr_o: got %h expected %h (access %0d)", got, exp, idx);
    end
  endtask

  task automatic check_count(input int idx, input int got, input int exp);
    if (got != exp) begin
      bus_errs++;
      $display("Mismatch data_req_o transactions: got %h expected %h (access %0d)",
               got, exp, idx);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one access, starting and ending on a falling edge
  ////////////////////////////////////////////////////////////
  task automatic run_access(input int idx);
    logic [31:0] op;
    logic [31:0] size;
    logic [31:0] addr;
    logic [31:0] expect_v;
    logic [31:0] mode;
    int          n_bytes;
    int          n_parts;
    logic        exp_err;
    op       = pat_mem[idx*pat_cols];
    size     = pat_mem[idx*pat_cols + 1];
    addr     = pat_mem[idx*pat_cols + 3];
    expect_v = pat_mem[idx*pat_cols + 5];
    mode     = pat_mem[idx*pat_cols + 6];
    n_bytes  = (size == 0) ? 4 : (size == 1) ? 2 : 1;
    n_parts  = (int'(addr[1:0]) + n_bytes > 4) ? 2 : 1;  // crosses into next word
    exp_err  = (mode == 1) || (mode == 2 && n_parts == 2);
    if (!lsu_ready) begin
      other_errs++;
      $display("lsu_ready_o low before access %0d", idx);
    end
    err_mode = int'(mode);
    txn_addr.delete();
    ex_req      = 1'b1;
    ex_we       = op[0];
    ex_size     = size[1:0];
    ex_sign_ext = pat_mem[idx*pat_cols + 2][0];
    ex_addr     = addr;
    ex_wdata    = pat_mem[idx*pat_cols + 4];
    @(negedge clk);
    ex_req   = 1'b0;
    ex_addr  = $urandom;  // held copy must be used from here on
    ex_wdata = $urandom;
    while (!resp_valid) begin
      if (lsu_ready) begin
        other_errs++;
        $display("lsu_ready_o high while access %0d is in flight", idx);
      end
      @(negedge clk);
    end
    if (op == 0) check_rdata(idx, resp_rdata, expect_v);
    check_err(idx, resp_err, exp_err);
    check_count(idx, txn_addr.size(), n_parts);
    for (int i = 0; i < n_parts && i < txn_addr.size(); i++) begin
      check_addr(idx, txn_addr[i], {addr[31:2], 2'b00} + 32'(4*i));
    end
  endtask

  initial begin
    void'($urandom(13));
    for (int i = 0; i < 256; i++) mem[i] = i[7:0];  // byte holds its own address
    for (int i = 0; i < max_pats*pat_cols; i++) pat_mem[i] = '1;
    $readmemh("bench/lsu_patterns.txt", pat_mem);
    n_pats = 0;
    while (n_pats < max_pats && pat_mem[n_pats*pat_cols] != 32'hffff_ffff) n_pats++;
    pats_loaded = 1'b1;
    if (n_pats == 0) begin
      other_errs++;
      $display("no access patterns were read");
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int p = 0; p < n_pats; p++) begin
      run_access(p);
      repeat ($urandom % 2) @(negedge clk);
    end
    repeat (2) @(negedge clk);
    asrt_errs = i_dut.bus_ctrl_i.bus_asrt_i.fail_cnt;
    $display("errors: rdata %0d, err flag %0d, bus %0d, other %0d, assertions %0d",
             rdata_errs, flag_errs, bus_errs, other_errs, asrt_errs);
    if (rdata_errs + flag_errs + bus_errs + other_errs + asrt_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // watchdog, 20 cycles per access after reset
  initial begin
    wait (pats_loaded);
    repeat (10 + n_pats*20) @(posedge clk);
    $display("timeout: accesses did not finish within %0d cycles", 10 + n_pats*20);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* hw/lsu_align.sv */
`timescale 1ns/1ps

module lsu_align (
  input  logic [lsu_pkg::addr_width-1:0]  addr_i,
  input  logic [lsu_pkg::size_width-1:0]  size_i,
  input  logic [lsu_pkg::data_width-1:0]  wdata_i,
  input  logic                            part_sel_i,   // 0 lower word, 1 next word

  output logic [lsu_pkg::addr_width-1:0]  word_addr_o,
  output logic [lsu_pkg::be_width-1:0]    be_o,
  output logic [lsu_pkg::data_width-1:0]  bus_wdata_o
);

  logic [1:0]                        offset;
  logic [lsu_pkg::be_width-1:0]      size_mask;  // lanes at offset 0
  logic [2*lsu_pkg::be_width-1:0]    be_wide;    // both parts side by side
  logic [2*lsu_pkg::data_width-1:0]  wdata_dbl;
  logic [lsu_pkg::addr_width-1:0]    base_addr;

  assign offset = addr_i[1:0];

  ////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (size_i)
      lsu_pkg::size_byte: size_mask = 4'b0001;
      lsu_pkg::size_half: size_mask = 4'b0011;
      default:            size_mask = 4'b1111;  // word
    endcase
  end

  // shifted mask, low nibble for part 0, spill-over in high nibble
  assign be_wide = {4'b0000, size_mask} << offset;
  assign be_o    = part_sel_i ? be_wide[7:4] : be_wide[3:0];

  ////////////////////////////////////////////////////////////
  // write data, rotated left by offset
  ////////////////////////////////////////////////////////////
  // same rotation serves both parts, lanes picked by be
  assign wdata_dbl   = {wdata_i, wdata_i} << {offset, 3'b000};
  assign bus_wdata_o = wdata_dbl[2*lsu_pkg::data_width-1:lsu_pkg::data_width];

  // aligned word address, +4 for second part
  assign base_addr   = {addr_i[lsu_pkg::addr_width-1:2], 2'b00};
  assign word_addr_o = part_sel_i ? base_addr + 32'd4 : base_addr;

endmodule

/* hw/lsu_bus_ctrl.sv */
`timescale 1ns/1ps

module lsu_bus_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  input  logic                            ex_req_i,
  input  logic                            two_part_i,
  input  logic                            we_i,
  input  logic [lsu_pkg::addr_width-1:0]  word_addr_i,
  input  logic [lsu_pkg::be_width-1:0]    be_i,
  input  logic [lsu_pkg::data_width-1:0]  bus_wdata_i,

  input  logic                            data_gnt_i,
  input  logic                            data_rvalid_i,
  input  logic                            data_err_i,

  output logic                            accept_o,
  output logic                            lsu_ready_o,
  output logic                            part_sel_o,
  output logic                            data_req_o,
  output logic [lsu_pkg::addr_width-1:0]  data_addr_o,
  output logic                            data_we_o,
  output logic [lsu_pkg::be_width-1:0]    data_be_o,
  output logic [lsu_pkg::data_width-1:0]  data_wdata_o,
  output logic                            rdata_lo_we_o,
  output logic                            rdata_hi_we_o,
  output logic                            resp_valid_o,
  output logic                            resp_err_o
);

  logic [1:0] state_q, state_d;
  logic       part_q;      // part currently on the bus
  logic       err_q;       // OR of data_err over parts
  logic       resp_q;
  logic       rvalid_ok;   // rvalid for our outstanding gnt
  logic       last_part;

  assign lsu_ready_o = (state_q == lsu_pkg::st_idle);
  assign accept_o    = ex_req_i & lsu_ready_o;
  assign rvalid_ok   = (state_q == lsu_pkg::st_wait) & data_rvalid_i;
  assign last_part   = ~two_part_i | part_q;

  ////////////////////////////////////////////////////////////
  // FSM: idle -> req -> wait (-> req -> wait) -> idle
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::st_idle: if (accept_o)      state_d = lsu_pkg::st_req;
      lsu_pkg::st_req:  if (data_gnt_i)    state_d = lsu_pkg::st_wait;
      lsu_pkg::st_wait: if (data_rvalid_i) state_d = last_part ? lsu_pkg::st_idle
                                                               : lsu_pkg::st_req;
      default:                             state_d = lsu_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= lsu_pkg::st_idle;
      part_q  <= 1'b0;
      err_q   <= 1'b0;
      resp_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      resp_q  <= rvalid_ok & last_part;  // one cycle after final rvalid
      if (accept_o) begin
        part_q <= 1'b0;                  // new access starts at lower word
        err_q  <= 1'b0;
      end else if (rvalid_ok) begin
        err_q <= err_q | data_err_i;
        if (!last_part) part_q <= 1'b1;  // spill-over word next
      end
    end
  end

  // bus side, payload comes straight from align
  assign data_req_o   = (state_q == lsu_pkg::st_req);
  assign data_addr_o  = word_addr_i;
  assign data_we_o    = we_i;
  assign data_be_o    = be_i;
  assign data_wdata_o = bus_wdata_i;

  assign part_sel_o    = part_q;
  assign rdata_lo_we_o = rvalid_ok & ~part_q;
  assign rdata_hi_we_o = rvalid_ok & part_q;
  assign resp_valid_o  = resp_q;
  assign resp_err_o    = err_q;

endmodule

/* hw/lsu_pkg.sv */
package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////
  localparam int unsigned data_width = 32;  // bus data
  localparam int unsigned addr_width = 32;  // byte address
  localparam int unsigned be_width   = 4;   // one enable per byte lane
  localparam int unsigned size_width = 2;

  // access size, same coding as the core's data_type
  localparam logic [size_width-1:0] size_word = 2'd0;
  localparam logic [size_width-1:0] size_half = 2'd1;
  localparam logic [size_width-1:0] size_byte = 2'd2;

  ////////////////////////////////////////////////////////////
  // bus controller states
  ////////////////////////////////////////////////////////////
  localparam logic [1:0] st_idle = 2'd0;  // ready for a new access
  localparam logic [1:0] st_req  = 2'd1;  // req high, waiting for gnt
  localparam logic [1:0] st_wait = 2'd2;  // granted, waiting for rvalid

  // one bus word
  // byte lanes for byte loads, halves for halfword loads
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } data_word_u;

endpackage

/* hw/lsu_rdata_ext.sv */
`timescale 1ns/1ps

module lsu_rdata_ext (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  input  logic [lsu_pkg::data_width-1:0]  data_rdata_i,
  input  logic                            lo_we_i,      // first part returned
  input  logic                            hi_we_i,      // second part returned

  // held request
  input  logic [lsu_pkg::addr_width-1:0]  addr_i,
  input  logic [lsu_pkg::size_width-1:0]  size_i,
  input  logic                            sign_ext_i,

  output logic [lsu_pkg::data_width-1:0]  resp_rdata_o
);

  logic [lsu_pkg::data_width-1:0]    lo_q;
  logic [lsu_pkg::data_width-1:0]    hi_q;
  logic [2*lsu_pkg::data_width-1:0]  merged;
  lsu_pkg::data_word_u               rot;
  logic [1:0]                        offset;

  assign offset = addr_i[1:0];

  ////////////////////////////////////////////////////////////
  // captured bus words
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lo_q <= '0;
      hi_q <= '0;
    end else begin
      if (lo_we_i) lo_q <= data_rdata_i;
      if (hi_we_i) hi_q <= data_rdata_i;
    end
  end

  // addressed byte lands in lane 0
  // hi only contributes for a two-part access
  assign merged = {hi_q, lo_q} >> {offset, 3'b000};
  assign rot    = merged[lsu_pkg::data_width-1:0];

  ////////////////////////////////////////////////////////////
  // extract and extend
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (size_i)
      lsu_pkg::size_byte:
        resp_rdata_o = {{24{sign_ext_i & rot.bytes[0][7]}}, rot.bytes[0]};
      lsu_pkg::size_half:
        resp_rdata_o = {{16{sign_ext_i & rot.halves[0][15]}}, rot.halves[0]};
      default:
        resp_rdata_o = rot;   // full word, nothing to extend
    endcase
  end

endmodule

/* hw/lsu_req_stage.sv */
`timescale 1ns/1ps

module lsu_req_stage (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // execute side
  input  logic                            ex_req_i,
  input  logic                            ex_we_i,
  input  logic [lsu_pkg::size_width-1:0]  ex_size_i,
  input  logic                            ex_sign_ext_i,
  input  logic [lsu_pkg::addr_width-1:0]  ex_addr_i,
  input  logic [lsu_pkg::data_width-1:0]  ex_wdata_i,
  input  logic                            accept_i,     // from bus controller

  // held request
  output logic                            we_o,
  output logic [lsu_pkg::size_width-1:0]  size_o,
  output logic                            sign_ext_o,
  output logic [lsu_pkg::addr_width-1:0]  addr_o,
  output logic [lsu_pkg::data_width-1:0]  wdata_o,
  output logic                            two_part_o
);

  logic load_en;
  logic [1:0] offset;

  assign load_en = accept_i & ex_req_i;  // accept already implies req
  assign offset  = addr_o[1:0];

  // access attributes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      we_o       <= 1'b0;
      size_o     <= lsu_pkg::size_word;
      sign_ext_o <= 1'b0;
    end else if (load_en) begin
      we_o       <= ex_we_i;
      size_o     <= ex_size_i;
      sign_ext_o <= ex_sign_ext_i;
    end
  end

  // address and store data
  always_ff @(posedge clk_i) begin
    if (load_en) begin
      addr_o  <= ex_addr_i;
      wdata_o <= ex_wdata_i;
    end
  end

  // crosses a word boundary -> second bus part
  // word at any nonzero offset, half only at offset 3
  assign two_part_o = ((size_o == lsu_pkg::size_word) && (offset != 2'd0)) ||
                      ((size_o == lsu_pkg::size_half) && (offset == 2'd3));

endmodule

/* hw/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // execute side
  input  logic                            ex_req_i,
  input  logic                            ex_we_i,
  input  logic [lsu_pkg::size_width-1:0]  ex_size_i,
  input  logic                            ex_sign_ext_i,
  input  logic [lsu_pkg::addr_width-1:0]  ex_addr_i,
  input  logic [lsu_pkg::data_width-1:0]  ex_wdata_i,
  output logic                            lsu_ready_o,

  // result
  output logic                            resp_valid_o,
  output logic [lsu_pkg::data_width-1:0]  resp_rdata_o,
  output logic                            resp_err_o,

  // data bus
  output logic                            data_req_o,
  input  logic                            data_gnt_i,
  input  logic                            data_rvalid_i,
  output logic                            data_we_o,
  output logic [lsu_pkg::be_width-1:0]    data_be_o,
  output logic [lsu_pkg::addr_width-1:0]  data_addr_o,
  output logic [lsu_pkg::data_width-1:0]  data_wdata_o,
  input  logic [lsu_pkg::data_width-1:0]  data_rdata_i,
  input  logic                            data_err_i
);

  logic                            accept;
  logic                            we_q;
  logic [lsu_pkg::size_width-1:0]  size_q;
  logic                            sign_ext_q;
  logic [lsu_pkg::addr_width-1:0]  addr_q;
  logic [lsu_pkg::data_width-1:0]  wdata_q;
  logic                            two_part;
  logic                            part_sel;
  logic [lsu_pkg::addr_width-1:0]  word_addr;
  logic [lsu_pkg::be_width-1:0]    be;
  logic [lsu_pkg::data_width-1:0]  bus_wdata;
  logic                            rdata_lo_we;
  logic                            rdata_hi_we;

  ////////////////////////////////////////////////////////////
  // request capture
  ////////////////////////////////////////////////////////////
  lsu_req_stage req_stage_i (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .ex_req_i      ( ex_req_i      ),
    .ex_we_i       ( ex_we_i       ),
    .ex_size_i     ( ex_size_i     ),
    .ex_sign_ext_i ( ex_sign_ext_i ),
    .ex_addr_i     ( ex_addr_i     ),
    .ex_wdata_i    ( ex_wdata_i    ),
    .accept_i      ( accept        ),
    .we_o          ( we_q          ),
    .size_o        ( size_q        ),
    .sign_ext_o    ( sign_ext_q    ),
    .addr_o        ( addr_q        ),
    .wdata_o       ( wdata_q       ),
    .two_part_o    ( two_part      )
  );

  // address, be and wdata of current part
  lsu_align align_i (
    .addr_i      ( addr_q    ),
    .size_i      ( size_q    ),
    .wdata_i     ( wdata_q   ),
    .part_sel_i  ( part_sel  ),
    .word_addr_o ( word_addr ),
    .be_o        ( be        ),
    .bus_wdata_o ( bus_wdata )
  );

  ////////////////////////////////////////////////////////////
  // bus side
  ////////////////////////////////////////////////////////////
  lsu_bus_ctrl bus_ctrl_i (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .ex_req_i      ( ex_req_i      ),
    .two_part_i    ( two_part      ),
    .we_i          ( we_q          ),
    .word_addr_i   ( word_addr     ),
    .be_i          ( be            ),
    .bus_wdata_i   ( bus_wdata     ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_err_i    ( data_err_i    ),
    .accept_o      ( accept        ),
    .lsu_ready_o   ( lsu_ready_o   ),
    .part_sel_o    ( part_sel      ),
    .data_req_o    ( data_req_o    ),
    .data_addr_o   ( data_addr_o   ),
    .data_we_o     ( data_we_o     ),
    .data_be_o     ( data_be_o     ),
    .data_wdata_o  ( data_wdata_o  ),
    .rdata_lo_we_o ( rdata_lo_we   ),
    .rdata_hi_we_o ( rdata_hi_we   ),
    .resp_valid_o  ( resp_valid_o  ),
    .resp_err_o    ( resp_err_o    )
  );

  lsu_rdata_ext rdata_ext_i (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .data_rdata_i ( data_rdata_i ),
    .lo_we_i      ( rdata_lo_we  ),
    .hi_we_i      ( rdata_hi_we  ),
    .addr_i       ( addr_q       ),
    .size_i       ( size_q       ),
    .sign_ext_i   ( sign_ext_q   ),
    .resp_rdata_o ( resp_rdata_o )
  );

endmodule

/* sources.f */
hw/lsu_pkg.sv
hw/lsu_req_stage.sv
hw/lsu_align.sv
hw/lsu_bus_ctrl.sv
hw/lsu_rdata_ext.sv
hw/lsu_top.sv
bench/lsu_clk_gen.sv
bench/lsu_assertions.sv
bench/lsu_tb.sv
